// File: design/qbus_pkg.sv
//////////////////////////////////////////////////
// qbus widths, register bank base, panel geometry
// and the bus word union (address / data views)
//////////////////////////////////////////////////

package qbus_pkg;

   // bus line widths
   localparam int DAL_W    = 22;   // data/address lines
   localparam int DATA_W   = 16;   // one bus data word
   localparam int OFFSET_W = 13;   // i/o page offset that gets decoded

   // device register bank, sits at the old test register slot
   localparam logic [OFFSET_W-1:0] REG_BASE  = 13'o17720;
   localparam logic [DATA_W-1:0]   REG_RESET = {DATA_W{1'b1}};  // bus init value

   // indicator panel
   localparam int PANEL_WORD_W = 36;   // bits per panel word
   localparam int PANEL_WORDS  = 4;    // words per frame
   localparam int PANEL_DIV    = 128;  // clk20 cycles per panel bit

   // address phase view of the dal lines
   typedef struct packed {
      logic [DAL_W-OFFSET_W-1:0] hi;      // upper address bits, not decoded
      logic [OFFSET_W-1:0]       offset;  // offset inside the i/o page
   } dal_addr_t;

   // data phase view, word sits in the low lines
   typedef struct packed {
      logic [DAL_W-DATA_W-1:0] pad;   // upper lines carry nothing
      logic [DATA_W-1:0]       word;
   } dal_data_t;

   // same 22 lines, decoded either way depending on the bus phase
   typedef union packed {
      dal_addr_t addr;
      dal_data_t data;
   } dal_word_t;

endpackage

// File: design/bus_sync.sv
//////////////////////////////////////////////////
// bus strobe synchronisers into clk20, with the
// settling taps and rising edge pulses
//////////////////////////////////////////////////

`timescale 1ns/10ps

module bus_sync (
   input  logic clk20,
   input  logic rst_n,
   input  logic rsync,
   input  logic rdin,
   input  logic rdout,
   input  logic rinit,
   output logic sync_s,      // synchronised rsync level
   output logic sync_rise,   // one cycle on rsync rising
   output logic din_s,
   output logic din_late,    // din_s one cycle later, lines have settled
   output logic dout_s,
   output logic dout_rise,
   output logic init_s
);

   // strobe bit positions: rinit, rsync, rdin, rdout
   localparam int I_INIT = 3;
   localparam int I_SYNC = 2;
   localparam int I_DIN  = 1;
   localparam int I_DOUT = 0;

   logic [3:0] meta;   // first flop, may go metastable
   logic [3:0] lvl;    // usable level, 2 cycles behind the pin
   logic [2:0] late;   // one more stage, rinit needs none

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         meta <= '0;
         lvl  <= '0;
         late <= '0;
      end else begin
         meta <= {rinit, rsync, rdin, rdout};
         lvl  <= meta;
         late <= lvl[2:0];
      end
   end

   assign sync_s    = lvl[I_SYNC];
   assign sync_rise = lvl[I_SYNC] & ~late[I_SYNC];
   assign din_s     = lvl[I_DIN];
   assign din_late  = late[I_DIN];
   assign dout_s    = lvl[I_DOUT];
   assign dout_rise = lvl[I_DOUT] & ~late[I_DOUT];
   assign init_s    = lvl[I_INIT];

   // sync edge pulse must never stretch, address capture relies on a single shot
   a_sync_rise_one: assert property (@(posedge clk20) disable iff (!rst_n)
      sync_rise |=> !sync_rise);

endmodule

// File: design/addr_capture.sv
//////////////////////////////////////////////////
// address phase capture and register bank decode
//////////////////////////////////////////////////

`timescale 1ns/10ps

module addr_capture import qbus_pkg::*; #(
   parameter int NUM_REGS = 4
) (
   input  logic                        clk20,
   input  logic                        rst_n,
   input  logic                        sync_rise,
   input  dal_word_t                   dal,
   input  logic                        bs7,
   input  logic                        wtbt,
   input  logic                        sync_s,
   output logic                        hit,
   output logic [$clog2(NUM_REGS)-1:0] reg_index,
   output logic                        read_cycle,
   output dal_word_t                   captured_addr,
   output logic                        captured_bs7
);

   localparam int IDX_W = $clog2(NUM_REGS);

   logic                cap_valid;   // capture belongs to the current cycle
   logic [OFFSET_W-1:0] rel;         // byte offset from register 0
   logic                in_range;

   // address is taken on the synchronised sync edge, so the master
   // has to hold it on dal for 3 clk20 cycles after rsync
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         captured_addr <= '0;
         captured_bs7  <= 1'b0;
         read_cycle    <= 1'b0;
         cap_valid     <= 1'b0;
      end else begin
         if (sync_rise) begin
            captured_addr <= dal;     // address view of the lines
            captured_bs7  <= bs7;     // i/o page select
            read_cycle    <= ~wtbt;   // wtbt low means DATI
         end
         if (sync_rise)
            cap_valid <= 1'b1;
         else if (!sync_s)
            cap_valid <= 1'b0;        // cycle over
      end
   end

   // below-base offsets wrap around to large values and miss
   assign rel      = captured_addr.addr.offset - REG_BASE;
   assign in_range = rel < OFFSET_W'(2 * NUM_REGS);

   // word index, byte bit ignored
   assign reg_index = rel[IDX_W:1];

   // only while rsync is still up and the capture is this cycle's
   assign hit = sync_s & cap_valid & captured_bs7 & in_range;

endmodule

// File: design/csr_bank.sv
//////////////////////////////////////////////////
// device register bank, DATO write, DATI read
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csr_bank import qbus_pkg::*; #(
   parameter int NUM_REGS = 4
) (
   input  logic                        clk20,
   input  logic                        rst_n,
   input  logic                        init_s,      // bus init, synchronised
   input  logic                        dout_rise,
   input  logic                        hit,
   input  logic                        read_cycle,
   input  logic [$clog2(NUM_REGS)-1:0] reg_index,
   input  logic [DATA_W-1:0]           wr_data,
   output logic [DATA_W-1:0]           rd_data,
   output logic [DATA_W-1:0]           reg0         // for the panel
);

   logic [DATA_W-1:0] regs [NUM_REGS];
   logic              wr_en;

   // write lands 3 cycles after rdout rises, data held by the master
   assign wr_en = dout_rise & hit & ~read_cycle;

   always_ff @(posedge clk20) begin
      if (!rst_n || init_s) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= REG_RESET;   // all ones like the old test register
         end
      end else if (wr_en) begin
         regs[reg_index] <= wr_data;
      end
   end

   // read mux, top level decides when it reaches the lines
   assign rd_data = regs[reg_index];
   assign reg0    = regs[0];

endmodule

// File: design/slave_reply.sv
//////////////////////////////////////////////////
// slave reply sequencer: trply and the dal
// transceiver controls for DATI / DATO
//////////////////////////////////////////////////

`timescale 1ns/10ps

module slave_reply (
   input  logic clk20,
   input  logic rst_n,
   input  logic hit,        // one of our registers, rsync still up
   input  logic din_s,
   input  logic din_late,
   input  logic dout_s,
   output logic trply,
   output logic dal_be_n,   // transceiver drive enable, active low
   output logic dal_st,     // output latch strobe
   output logic dal_tx      // transceiver direction, high = to the bus
);

   // everything is rebuilt each cycle from the synchronised levels,
   // so a dropped strobe clears the outputs on the next edge
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         trply    <= 1'b0;
         dal_be_n <= 1'b1;
         dal_st   <= 1'b0;
         dal_tx   <= 1'b0;
      end else begin
         // idle unless a hit cycle says otherwise
         trply    <= 1'b0;
         dal_be_n <= 1'b1;
         dal_st   <= 1'b0;
         dal_tx   <= 1'b0;

         if (hit) begin
            if (din_s) begin
               // DATI: turn the transceivers round first
               dal_tx <= 1'b1;
               // one cycle later, so the lines to the transceivers settle
               if (din_late) begin
                  trply    <= 1'b1;   // bus allows data up to 125ns after reply
                  dal_be_n <= 1'b0;
                  dal_st   <= 1'b1;
               end
            end else if (dout_s) begin
               // DATO: register loaded on the same edge
               trply <= 1'b1;
            end
         end
      end
   end

   // never drive the bus with the transceivers pointing inward
   a_be_needs_tx: assert property (@(posedge clk20) disable iff (!rst_n)
      !dal_be_n |-> dal_tx);

   // a reply only ever answers an addressed cycle
   a_reply_on_hit: assert property (@(posedge clk20) disable iff (!rst_n)
      $rose(trply) |-> $past(hit));

endmodule

// File: design/panel_driver.sv
//////////////////////////////////////////////////
// indicator panel: bit clock, frame count,
// snapshot of bus state and serial shift out
//////////////////////////////////////////////////

`timescale 1ns/10ps

module panel_driver import qbus_pkg::*; (
   input  logic              clk20,
   input  logic              rst_n,
   input  logic              init_s,
   input  logic              dal_tx,
   input  dal_word_t         dal,             // raw bus lines
   input  logic              read_cycle,
   input  logic              bs7,             // captured bs7
   input  dal_word_t         captured_addr,
   input  logic              trply,
   input  logic [DATA_W-1:0] reg0,
   output logic              ip_clk,
   output logic              ip_latch,
   output logic              ip_out
);

   localparam int FRAME_BITS = PANEL_WORDS * PANEL_WORD_W;   // 144
   localparam int DIV_W      = $clog2(PANEL_DIV);
   localparam int CNT_W      = $clog2(FRAME_BITS + 1);       // one extra slot for latch

   logic [DIV_W-1:0]        div;
   logic [CNT_W-1:0]        bit_cnt;   // FRAME_BITS means latch slot
   logic [FRAME_BITS-1:0]   shreg;
   logic                    bit_tick;
   logic                    latch_slot;
   logic [PANEL_WORD_W-1:0] w0;
   logic [PANEL_WORD_W-1:0] w1;
   logic [PANEL_WORD_W-1:0] w2;
   logic [PANEL_WORD_W-1:0] w3;

   // panel words, msb lamp first
   assign w0 = {dal_tx, 1'b0, dal, {(PANEL_WORD_W - DAL_W - 2){1'b0}}};
   assign w1 = {read_cycle, bs7, captured_addr, {(PANEL_WORD_W - DAL_W - 2){1'b0}}};
   assign w2 = {trply, {(PANEL_WORD_W - 1){1'b0}}};
   assign w3 = {reg0, {(PANEL_WORD_W - DATA_W){1'b0}}};

   assign bit_tick   = (div == DIV_W'(PANEL_DIV - 1));     // end of a bit time
   assign latch_slot = (bit_cnt == CNT_W'(FRAME_BITS));

   always_ff @(posedge clk20) begin
      if (!rst_n || init_s) begin
         div      <= '0;
         bit_cnt  <= '0;
         shreg    <= '0;      // first frame after reset shows dark
         ip_clk   <= 1'b0;
         ip_latch <= 1'b0;
      end else begin
         div <= bit_tick ? '0 : div + 1'b1;

         if (bit_tick) begin
            if (latch_slot) begin
               shreg   <= {w0, w1, w2, w3};   // snapshot at frame start
               bit_cnt <= '0;
            end else begin
               shreg   <= shreg << 1;
               bit_cnt <= bit_cnt + 1'b1;
            end
         end

         // clock high in second half of a bit, data changed half a bit earlier
         ip_clk   <= (div >= DIV_W'(PANEL_DIV / 2)) && !latch_slot;
         ip_latch <= latch_slot;   // one bit time between frames
      end
   end

   assign ip_out = shreg[FRAME_BITS-1];

endmodule

// File: design/qsic_top.sv
//////////////////////////////////////////////////
// qbus slave top: module wiring and dal drive
//////////////////////////////////////////////////

`timescale 1ns/10ps

module qsic_top import qbus_pkg::*; #(
   parameter int NUM_REGS = 4
) (
   input  logic             clk20,
   input  logic             rst_n,
   input  logic             rsync,
   input  logic             rdin,
   input  logic             rdout,
   input  logic             rinit,
   input  logic             bs7,
   input  logic             wtbt,     // only the read/write flag here
   inout  wire [DAL_W-1:0]  dal,
   output logic             trply,
   output logic             dal_be_n,
   output logic             dal_st,
   output logic             dal_tx,
   output logic             ip_clk,
   output logic             ip_latch,
   output logic             ip_out
);

   localparam int IDX_W = $clog2(NUM_REGS);

   logic              sync_s, sync_rise, din_s, din_late, dout_s, dout_rise, init_s;
   logic              hit, read_cycle, captured_bs7;
   logic [IDX_W-1:0]  reg_index;
   logic [DATA_W-1:0] rd_data, reg0;
   dal_word_t         dal_in;          // what the lines carry right now
   dal_word_t         dal_drv;         // what we put on them during DATI
   dal_word_t         captured_addr;

   assign dal_in = dal;

   // data view, upper lines low
   always_comb begin
      dal_drv           = '0;
      dal_drv.data.word = rd_data;
   end

   assign dal = dal_tx ? dal_drv : {DAL_W{1'bz}};

   bus_sync i_bus_sync (
      .clk20, .rst_n, .rsync, .rdin, .rdout, .rinit,
      .sync_s, .sync_rise, .din_s, .din_late, .dout_s, .dout_rise, .init_s
   );

   addr_capture #(.NUM_REGS(NUM_REGS)) i_addr_capture (
      .clk20, .rst_n, .sync_rise, .dal(dal_in), .bs7, .wtbt, .sync_s,
      .hit, .reg_index, .read_cycle, .captured_addr, .captured_bs7
   );

   csr_bank #(.NUM_REGS(NUM_REGS)) i_csr_bank (
      .clk20, .rst_n, .init_s, .dout_rise, .hit, .read_cycle, .reg_index,
      .wr_data(dal_in.data.word), .rd_data, .reg0
   );

   slave_reply i_slave_reply (
      .clk20, .rst_n, .hit, .din_s, .din_late, .dout_s,
      .trply, .dal_be_n, .dal_st, .dal_tx
   );

   panel_driver i_panel_driver (
      .clk20, .rst_n, .init_s, .dal_tx, .dal(dal_in), .read_cycle,
      .bs7(captured_bs7), .captured_addr, .trply, .reg0,
      .ip_clk, .ip_latch, .ip_out
   );

endmodule

// File: dv/qsic_tb_checks.svh
//////////////////////////////////////////////////
// compare tasks, error counters, cycle watchdog
//////////////////////////////////////////////////

`ifndef QSIC_TB_CHECKS_SVH
`define QSIC_TB_CHECKS_SVH

int check_count  = 0;      // every compare made
int value_errors = 0;      // wrong values seen
int other_errors = 0;      // missing replies, bad vectors, stuck lines
int cycle_cnt    = 0;
int cycle_limit  = 1000;   // raised once the vectors are counted

// one data word, read back from the bus or the panel
task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
   check_count++;
   if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      value_errors++;
   end
endtask

// full set of bus lines, address or data view
task automatic check_word(input string name, input dal_word_t exp, input dal_word_t act);
   check_count++;
   if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      value_errors++;
   end
endtask

// single control line or flag
task automatic check_bit(input string name, input logic exp, input logic act);
   check_count++;
   if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      value_errors++;
   end
endtask

// ends a run that stops making progress
initial begin
   while (cycle_cnt < cycle_limit) begin
      @(posedge clk20);
      cycle_cnt++;
   end
   $display("timeout: run still going after %0d clk20 cycles", cycle_cnt);
   $display("SOME TESTS FAILED");
   $finish;
end

`endif

// File: dv/qsic_tb.sv
//////////////////////////////////////////////////
// qbus slave testbench: clock, reset, vector
// driven bus cycles, panel capture, report
//////////////////////////////////////////////////

`timescale 1ns/10ps

module qsic_tb import qbus_pkg::*; ();

   localparam int NUM_REGS     = 4;
   localparam int ADDR_HOLD    = 4;    // clk20 cycles the address stays after rsync
   localparam int IDLE_GAP     = 4;    // quiet cycles between bus cycles
   localparam int REPLY_WAIT   = 20;   // longest wait for a trply edge
   localparam int FRAME_BITS   = PANEL_WORDS * PANEL_WORD_W;
   localparam int FRAME_CYCLES = (FRAME_BITS + 1) * PANEL_DIV;   // bits plus latch slot

   logic      clk20 = 1'b0;
   logic      rst_n, rsync, rdin, rdout, rinit, bs7, wtbt;
   logic      trply, dal_be_n, dal_st, dal_tx, ip_clk, ip_latch, ip_out;
   wire [DAL_W-1:0] dal;
   dal_word_t dal_drv;      // master side of the lines
   logic      dal_oe;

   logic [DATA_W-1:0] model [NUM_REGS];   // expected register contents
   dal_word_t         last_addr;          // what the slave should have captured
   logic              last_bs7;
   logic              last_read;

   // vectors, one entry per file line
   logic [7:0]        vop [$];
   dal_word_t         vaddr [$];
   logic              vbs7 [$];
   logic [DATA_W-1:0] vwd [$];
   logic [DATA_W-1:0] vrd [$];

   `include "qsic_tb_checks.svh"

   always #10 clk20 = ~clk20;   // 20 ns period

   assign dal = dal_oe ? dal_drv : {DAL_W{1'bz}};

   qsic_top #(.NUM_REGS(NUM_REGS)) i_qsic_top (
      .clk20, .rst_n, .rsync, .rdin, .rdout, .rinit, .bs7, .wtbt, .dal,
      .trply, .dal_be_n, .dal_st, .dal_tx, .ip_clk, .ip_latch, .ip_out
   );

   // inputs move 2 ns after the edge
   task automatic tick();
      @(posedge clk20);
      #2;
   endtask

   // word index in the bank, -1 when the cycle is not ours
   function automatic int bank_index(input dal_word_t a, input logic b7);
      logic [OFFSET_W-1:0] rel;
      rel = a.addr.offset - REG_BASE;   // below base wraps high
      if (!b7 || rel >= 2 * NUM_REGS)
         return -1;
      return int'(rel >> 1);
   endfunction

   task automatic wait_trply(input logic level, output logic seen);
      seen = 1'b0;
      for (int n = 0; n < REPLY_WAIT && !seen; n++) begin
         tick();
         if (trply === level)
            seen = 1'b1;
      end
   endtask

   task automatic check_reply(input string name, input logic want, input logic seen);
      if (want && !seen) begin
         $display("%s: no reply from the slave within %0d cycles", name, REPLY_WAIT);
         other_errors++;
      end else if (!want && seen) begin
         $display("%s: slave replied to a cycle outside its registers", name);
         other_errors++;
      end
   endtask

   task automatic release_reply(input string name, input logic seen);
      logic dropped;
      if (seen) begin
         wait_trply(1'b0, dropped);
         if (!dropped) begin
            $display("%s: trply stayed high after the strobe fell", name);
            other_errors++;
         end
      end
   endtask

   // address phase, master holds the lines well past the sync edge
   task automatic begin_cycle(input dal_word_t addr, input logic b7, input logic wr);
      tick();
      dal_drv   = addr;
      dal_oe    = 1'b1;
      bs7       = b7;
      wtbt      = wr;
      last_addr = addr;
      last_bs7  = b7;
      last_read = ~wr;
      tick();
      rsync = 1'b1;
      repeat (ADDR_HOLD) tick();
   endtask

   task automatic end_cycle();
      rsync  = 1'b0;
      bs7    = 1'b0;
      wtbt   = 1'b0;
      dal_oe = 1'b0;
      repeat (IDLE_GAP) tick();
   endtask

   task automatic bus_read(input string name, input dal_word_t addr, input logic b7,
                           input logic [DATA_W-1:0] exp, input logic want);
      logic      seen;
      dal_word_t got;
      dal_word_t floating;
      floating = {DAL_W{1'bz}};
      begin_cycle(addr, b7, 1'b0);
      dal_oe = 1'b0;            // slave turns the lines round
      rdin   = 1'b1;
      wait_trply(1'b1, seen);
      check_reply(name, want, seen);
      got = dal;                // sampled with trply high
      if (seen) begin
         check_data(name, exp, got.data.word);
         // transceivers out, enabled and latched along with the reply
         check_bit({name, " dal_tx"}, 1'b1, dal_tx);
         check_bit({name, " dal_be_n"}, 1'b0, dal_be_n);
         check_bit({name, " dal_st"}, 1'b1, dal_st);
      end else begin
         check_word(name, floating, got);   // nobody drives
         check_bit({name, " dal_tx"}, 1'b0, dal_tx);
         check_bit({name, " dal_be_n"}, 1'b1, dal_be_n);
         check_bit({name, " dal_st"}, 1'b0, dal_st);
      end
      rdin = 1'b0;
      release_reply(name, seen);
      end_cycle();
   endtask

   task automatic bus_write(input string name, input dal_word_t addr, input logic b7,
                            input logic [DATA_W-1:0] data, input logic want);
      logic seen;
      begin_cycle(addr, b7, 1'b1);
      dal_drv           = '0;
      dal_drv.data.word = data;   // data phase view
      rdout             = 1'b1;
      wait_trply(1'b1, seen);
      check_reply(name, want, seen);
      // master owns the lines, transceivers stay inward
      check_bit({name, " dal_tx"}, 1'b0, dal_tx);
      check_bit({name, " dal_be_n"}, 1'b1, dal_be_n);
      rdout = 1'b0;
      release_reply(name, seen);
      end_cycle();
   endtask

   task automatic bus_init();
      tick();
      rinit = 1'b1;
      repeat (5) tick();
      rinit = 1'b0;
      repeat (IDLE_GAP) tick();
      for (int i = 0; i < NUM_REGS; i++)
         model[i] = REG_RESET;
   endtask

   // one frame between two latch pulses, msb first
   task automatic panel_frame(input string name);
      logic [FRAME_BITS-1:0]   frame;
      logic [PANEL_WORD_W-1:0] w1;
      logic [PANEL_WORD_W-1:0] w3;
      frame = '0;
      @(negedge ip_latch);
      for (int b = 0; b < FRAME_BITS; b++) begin
         @(posedge ip_clk);
         frame = {frame[FRAME_BITS-2:0], ip_out};
      end
      @(posedge ip_latch);
      w1 = frame[2*PANEL_WORD_W +: PANEL_WORD_W];
      w3 = frame[0 +: PANEL_WORD_W];
      check_bit({name, " read flag"}, last_read, w1[PANEL_WORD_W-1]);
      check_bit({name, " bs7"}, last_bs7, w1[PANEL_WORD_W-2]);
      check_word({name, " address"}, last_addr, w1[PANEL_WORD_W-3 -: DAL_W]);
      check_data({name, " register 0"}, model[0], w3[PANEL_WORD_W-1 -: DATA_W]);
   endtask

   task automatic load_vectors();
      int                fd;
      int                r;
      logic [7:0]        op;
      logic [DAL_W-1:0]  a;
      logic              b;
      logic [DATA_W-1:0] wd;
      logic [DATA_W-1:0] rd;
      logic [8*160-1:0]  rest;
      fd = $fopen("dv/qsic_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file dv/qsic_vectors.txt");
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", op);
            if (r == 1 && op == "#") begin
               r = $fgets(rest, fd);   // comment line
            end else if (r == 1) begin
               r = $fscanf(fd, "%o %d %h %h", a, b, wd, rd);
               if (r == 4) begin
                  vop.push_back(op);
                  vaddr.push_back(a);
                  vbs7.push_back(b);
                  vwd.push_back(wd);
                  vrd.push_back(rd);
               end else begin
                  $display("malformed line in the vector file after %0d vectors", vop.size());
                  other_errors++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      string name;
      int    idx;
      rst_n = 1'b0;
      rsync = 1'b0;
      rdin  = 1'b0;
      rdout = 1'b0;
      rinit = 1'b0;
      bs7   = 1'b0;
      wtbt  = 1'b0;
      dal_oe  = 1'b0;
      dal_drv = '0;
      last_addr = '0;
      last_bs7  = 1'b0;
      last_read = 1'b0;
      for (int i = 0; i < NUM_REGS; i++)
         model[i] = REG_RESET;
      load_vectors();
      cycle_limit = vop.size() * 40 + 3 * FRAME_CYCLES;

      repeat (4) tick();   // reset held 4 cycles
      rst_n = 1'b1;
      tick();
      check_bit("reset trply", 1'b0, trply);
      check_bit("reset dal_st", 1'b0, dal_st);
      check_bit("reset dal_tx", 1'b0, dal_tx);
      check_bit("reset dal_be_n", 1'b1, dal_be_n);
      check_bit("reset ip_latch", 1'b0, ip_latch);

      for (int i = 0; i < vop.size(); i++) begin
         name = $sformatf("vector %0d (%c %o)", i + 1, vop[i], vaddr[i]);
         idx  = bank_index(vaddr[i], vbs7[i]);
         case (vop[i])
            "R": begin
               if (idx >= 0 && model[idx] !== vrd[i]) begin
                  $display("%s: vector file expects %h but the register model holds %h",
                           name, vrd[i], model[idx]);
                  other_errors++;
               end
               bus_read(name, vaddr[i], vbs7[i], vrd[i], 1'b1);
            end
            "N": bus_read(name, vaddr[i], vbs7[i], vrd[i], 1'b0);
            "W": begin
               bus_write(name, vaddr[i], vbs7[i], vwd[i], 1'b1);
               if (idx >= 0)
                  model[idx] = vwd[i];
            end
            "X": bus_write(name, vaddr[i], vbs7[i], vwd[i], 1'b0);
            "I": bus_init();
            "P": panel_frame(name);
            default: begin
               $display("%s: unknown operation in the vector file", name);
               other_errors++;
            end
         endcase
      end

      $display("checks %0d, value mismatches %0d, other failures %0d",
               check_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: dv/qsic_vectors.txt
# op  address(octal)  bs7  write data(hex)  expected read data(hex)
# R read, W write, N read with no reply, X write with no reply, I bus init, P panel frame
R 17777720 1 0000 ffff
R 17777722 1 0000 ffff
R 17777724 1 0000 ffff
R 17777726 1 0000 ffff
W 17777720 1 1234 0000
R 17777720 1 0000 1234
R 17777722 1 0000 ffff
W 17777722 1 a5a5 0000
W 17777724 1 5a5a 0000
W 17777726 1 0f0f 0000
R 17777726 1 0000 0f0f
R 17777722 1 0000 a5a5
R 17777720 1 0000 1234
N 17777730 1 0000 0000
N 17777716 1 0000 0000
X 17777720 0 dead 0000
X 17777700 1 beef 0000
N 17777722 0 0000 0000
R 17777720 1 0000 1234
W 17777720 1 c3c3 0000
R 17777724 1 0000 5a5a
P 00000000 0 0000 0000
I 00000000 0 0000 0000
R 17777720 1 0000 ffff
R 17777722 1 0000 ffff
R 17777724 1 0000 ffff
R 17777726 1 0000 ffff

// File: files.f
+incdir+dv
design/qbus_pkg.sv
design/bus_sync.sv
design/addr_capture.sv
design/csr_bank.sv
design/slave_reply.sv
design/panel_driver.sv
design/qsic_top.sv
dv/qsic_tb.sv
